// ==== verilog/scalar_config.svh ====
`ifndef SCALAR_CONFIG_SVH
`define SCALAR_CONFIG_SVH

// Data path and instruction widths
`define SCALAR_DATA_WIDTH 32
`define SCALAR_INSTR_WIDTH 32
`define SCALAR_IMM_WIDTH 16
`define SCALAR_OP_WIDTH 4

// Storage depths
`define SCALAR_NUM_REGS 16
`define SCALAR_IMEM_DEPTH 64
`define SCALAR_NUM_LANES 8

// Field positions, opcode on top and imm16 at the bottom
`define SCALAR_OP_LSB 28
`define SCALAR_DST_LSB 24
`define SCALAR_SRC1_LSB 20
`define SCALAR_SRC2_LSB 16

`endif

// ==== verilog/scalar_pkg.sv ====
`include "scalar_config.svh"

package scalar_pkg;

	////////////////////
	// Data and address types

	typedef logic [`SCALAR_DATA_WIDTH-1:0] data_t;
	typedef logic [`SCALAR_INSTR_WIDTH-1:0] instr_t;
	typedef logic [$clog2(`SCALAR_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [$clog2(`SCALAR_IMEM_DEPTH)-1:0] pc_t;
	typedef logic [`SCALAR_NUM_LANES-1:0] lane_t;

	////////////////////
	// Opcodes

	typedef enum logic [`SCALAR_OP_WIDTH-1:0] {
		op_nop = 4'h0,
		op_add = 4'h1,
		op_sub = 4'h2,
		op_and = 4'h3,
		op_or = 4'h4,
		op_xor = 4'h5,
		op_shl = 4'h6,
		op_ldi = 4'h7,
		op_jmp = 4'h8,
		op_bz = 4'h9,
		op_lane = 4'ha,
		op_halt = 4'hb
	} op_t;

	// Flags of the last register write
	typedef struct packed {
		logic zero;
		logic negative;
	} status_t;

endpackage

// ==== verilog/instr_mem.sv ====
`include "scalar_config.svh"

module instr_mem (
	input logic clock,
	input logic reset,
	input logic req_st,
	input scalar_pkg::instr_t instr,
	output logic ack_st,
	input logic fetch_req,
	input scalar_pkg::pc_t fetch_pc,
	output scalar_pkg::instr_t fetch_instr
);

	import scalar_pkg::*;

	instr_t mem [`SCALAR_IMEM_DEPTH];
	pc_t st_addr;

	// Store side, words land at consecutive addresses from 0
	always_ff @(posedge clock) begin
		if (reset) begin
			st_addr <= '0;
			ack_st <= 1'b0;
		end else begin
			ack_st <= req_st;
			if (req_st) begin
				st_addr <= st_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_st) begin
			mem[st_addr] <= instr;
		end
		// Fetch port, word valid the next cycle
		if (fetch_req) begin
			fetch_instr <= mem[fetch_pc];
		end
	end

	ack_follows_req: assert property (@(posedge clock) disable iff (reset)
		ack_st == $past(req_st));

endmodule

// ==== verilog/scalar_decode.sv ====
`include "scalar_config.svh"

module scalar_decode (
	input logic clock,
	input logic reset,
	input logic en,
	input logic start,
	input scalar_pkg::instr_t fetch_instr,
	output logic fetch_req,
	output scalar_pkg::pc_t fetch_pc,
	input logic redirect,
	input scalar_pkg::pc_t redirect_pc,
	input logic halted,
	output scalar_pkg::reg_idx_t rf_ra1,
	output scalar_pkg::reg_idx_t rf_ra2,
	input scalar_pkg::data_t rf_rd1,
	input scalar_pkg::data_t rf_rd2,
	input logic wr_valid,
	input scalar_pkg::reg_idx_t wr_dst,
	input scalar_pkg::data_t wr_data,
	output logic dec_valid,
	output scalar_pkg::op_t dec_op,
	output scalar_pkg::reg_idx_t dec_dst,
	output scalar_pkg::data_t dec_src1_data,
	output scalar_pkg::data_t dec_src2_data,
	output logic [`SCALAR_IMM_WIDTH-1:0] dec_imm
);

	import scalar_pkg::*;

	pc_t pc;
	logic running;
	logic fetch_valid;
	logic kill;
	op_t op_field;
	reg_idx_t dst_field;
	logic [`SCALAR_IMM_WIDTH-1:0] imm_field;
	reg_idx_t src1_idx;
	reg_idx_t src2_idx;
	data_t src1_q;
	data_t src2_q;
	logic bypass1;
	logic bypass2;

	////////////////////
	// Fetch control

	// Branch or halt in execute drops both younger stages
	assign kill = redirect | halted;
	assign fetch_req = running & en & ~kill;
	assign fetch_pc = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			running <= 1'b0;
			fetch_valid <= 1'b0;
			dec_valid <= 1'b0;
		end else if (start) begin
			pc <= '0;
			running <= 1'b1;
			fetch_valid <= 1'b0;
			dec_valid <= 1'b0;
		end else if (en) begin
			fetch_valid <= fetch_req;
			dec_valid <= fetch_valid & ~kill;
			if (halted) begin
				running <= 1'b0;
			end
			if (redirect) begin
				pc <= redirect_pc;
			end else if (fetch_req) begin
				pc <= pc + 1'b1;
			end
		end
	end

	////////////////////
	// Field split and operand read

	assign op_field = op_t'(fetch_instr[`SCALAR_OP_LSB +: `SCALAR_OP_WIDTH]);
	assign dst_field = fetch_instr[`SCALAR_DST_LSB +: $bits(reg_idx_t)];
	assign rf_ra1 = fetch_instr[`SCALAR_SRC1_LSB +: $bits(reg_idx_t)];
	assign rf_ra2 = fetch_instr[`SCALAR_SRC2_LSB +: $bits(reg_idx_t)];
	assign imm_field = fetch_instr[`SCALAR_IMM_WIDTH-1:0];

	always_ff @(posedge clock) begin
		if (en) begin
			dec_op <= op_field;
			dec_dst <= dst_field;
			dec_imm <= imm_field;
			src1_idx <= rf_ra1;
			src2_idx <= rf_ra2;
			src1_q <= rf_rd1;
			src2_q <= rf_rd2;
		end
	end

	// Result of the instruction just ahead is still in the execute register
	assign bypass1 = wr_valid && (src1_idx != '0) && (wr_dst == src1_idx);
	assign bypass2 = wr_valid && (src2_idx != '0) && (wr_dst == src2_idx);
	assign dec_src1_data = bypass1 ? wr_data : src1_q;
	assign dec_src2_data = bypass2 ? wr_data : src2_q;

endmodule

// ==== verilog/scalar_execute.sv ====
`include "scalar_config.svh"

module scalar_execute (
	input logic clock,
	input logic reset,
	input logic en,
	input logic dec_valid,
	input scalar_pkg::op_t dec_op,
	input scalar_pkg::reg_idx_t dec_dst,
	input scalar_pkg::data_t dec_src1_data,
	input scalar_pkg::data_t dec_src2_data,
	input logic [`SCALAR_IMM_WIDTH-1:0] dec_imm,
	output logic redirect,
	output scalar_pkg::pc_t redirect_pc,
	output logic halted,
	output logic wr_valid,
	output scalar_pkg::reg_idx_t wr_dst,
	output scalar_pkg::data_t wr_data,
	output logic lane_we,
	output scalar_pkg::lane_t lane_data
);

	import scalar_pkg::*;

	data_t alu_result;
	logic alu_writes;
	logic src1_zero;

	////////////////////
	// ALU

	always_comb begin
		alu_writes = 1'b1;
		case (dec_op)
			op_add: alu_result = dec_src1_data + dec_src2_data;
			op_sub: alu_result = dec_src1_data - dec_src2_data;
			op_and: alu_result = dec_src1_data & dec_src2_data;
			op_or: alu_result = dec_src1_data | dec_src2_data;
			op_xor: alu_result = dec_src1_data ^ dec_src2_data;
			op_shl: alu_result = dec_src1_data << dec_src2_data[4:0];
			op_ldi: alu_result = {{(`SCALAR_DATA_WIDTH-`SCALAR_IMM_WIDTH)
				{dec_imm[`SCALAR_IMM_WIDTH-1]}}, dec_imm};
			default: begin
				// Control ops leave the register file alone
				alu_result = '0;
				alu_writes = 1'b0;
			end
		endcase
	end

	////////////////////
	// Branch, jump and halt

	assign src1_zero = (dec_src1_data == '0);
	assign redirect = dec_valid & ((dec_op == op_jmp) | ((dec_op == op_bz) & src1_zero));
	assign redirect_pc = dec_imm[$bits(pc_t)-1:0];
	assign halted = dec_valid & (dec_op == op_halt);

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_valid <= 1'b0;
			lane_we <= 1'b0;
		end else if (en) begin
			wr_valid <= dec_valid & alu_writes & (dec_dst != '0);
			lane_we <= dec_valid & (dec_op == op_lane);
		end
	end

	always_ff @(posedge clock) begin
		if (en) begin
			wr_dst <= dec_dst;
			wr_data <= alu_result;
			lane_data <= dec_src1_data[`SCALAR_NUM_LANES-1:0];
		end
	end

	redirect_halt_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(redirect && halted));

endmodule

// ==== verilog/scalar_result.sv ====
`include "scalar_config.svh"

module scalar_result (
	input logic clock,
	input logic reset,
	input logic en,
	input logic start,
	input logic halted,
	input scalar_pkg::reg_idx_t rf_ra1,
	input scalar_pkg::reg_idx_t rf_ra2,
	output scalar_pkg::data_t rf_rd1,
	output scalar_pkg::data_t rf_rd2,
	input logic wr_valid,
	input scalar_pkg::reg_idx_t wr_dst,
	input scalar_pkg::data_t wr_data,
	input logic lane_we,
	input scalar_pkg::lane_t lane_data,
	output logic scalar_valid,
	output scalar_pkg::data_t scalar_data,
	output scalar_pkg::status_t status,
	output scalar_pkg::lane_t lane_en,
	output logic term
);

	import scalar_pkg::*;

	data_t regs [`SCALAR_NUM_REGS];
	logic rf_we;

	////////////////////
	// Register file, write-first

	assign rf_we = wr_valid & en;

	always_ff @(posedge clock) begin
		if (rf_we && (wr_dst != '0)) begin
			regs[wr_dst] <= wr_data;
		end
	end

	// r0 is hardwired to zero
	assign rf_rd1 = (rf_ra1 == '0) ? '0 :
		(rf_we && (wr_dst == rf_ra1)) ? wr_data : regs[rf_ra1];
	assign rf_rd2 = (rf_ra2 == '0) ? '0 :
		(rf_we && (wr_dst == rf_ra2)) ? wr_data : regs[rf_ra2];

	// Every write also goes out to the vector unit
	assign scalar_valid = rf_we;
	assign scalar_data = wr_data;

	////////////////////
	// Status, lanes and termination

	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
			lane_en <= '0;
			term <= 1'b0;
		end else begin
			if (rf_we) begin
				status.zero <= (wr_data == '0);
				status.negative <= wr_data[`SCALAR_DATA_WIDTH-1];
			end
			if (en && lane_we) begin
				lane_en <= lane_data;
			end
			if (start) begin
				term <= 1'b0;
			end else if (en && halted) begin
				term <= 1'b1;
			end
		end
	end

	no_write_after_term: assert property (@(posedge clock) disable iff (reset)
		term |-> !scalar_valid);

endmodule

// ==== verilog/scalar_unit.sv ====
module scalar_unit (
	input logic clock,
	input logic reset,
	input logic en,
	input logic start,
	input logic req_st,
	input scalar_pkg::instr_t instr,
	output logic ack_st,
	output logic scalar_valid,
	output scalar_pkg::data_t scalar_data,
	output scalar_pkg::status_t status,
	output scalar_pkg::lane_t lane_en,
	output logic term
);

	import scalar_pkg::*;

	// Fetch
	logic fetch_req;
	pc_t fetch_pc;
	instr_t fetch_instr;

	// Register file read
	reg_idx_t rf_ra1;
	reg_idx_t rf_ra2;
	data_t rf_rd1;
	data_t rf_rd2;

	// Decode to execute
	logic dec_valid;
	op_t dec_op;
	reg_idx_t dec_dst;
	data_t dec_src1_data;
	data_t dec_src2_data;
	logic [$bits(dec_src1_data)/2-1:0] dec_imm;

	// Execute back to decode and on to result
	logic redirect;
	pc_t redirect_pc;
	logic halted;
	logic wr_valid;
	reg_idx_t wr_dst;
	data_t wr_data;
	logic lane_we;
	lane_t lane_data;

	instr_mem instr_mem_i (
		.clock(clock),
		.reset(reset),
		.req_st(req_st),
		.instr(instr),
		.ack_st(ack_st),
		.fetch_req(fetch_req),
		.fetch_pc(fetch_pc),
		.fetch_instr(fetch_instr)
	);

	scalar_decode scalar_decode_i (
		.clock(clock),
		.reset(reset),
		.en(en),
		.start(start),
		.fetch_instr(fetch_instr),
		.fetch_req(fetch_req),
		.fetch_pc(fetch_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halted(halted),
		.rf_ra1(rf_ra1),
		.rf_ra2(rf_ra2),
		.rf_rd1(rf_rd1),
		.rf_rd2(rf_rd2),
		.wr_valid(wr_valid),
		.wr_dst(wr_dst),
		.wr_data(wr_data),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_dst(dec_dst),
		.dec_src1_data(dec_src1_data),
		.dec_src2_data(dec_src2_data),
		.dec_imm(dec_imm)
	);

	scalar_execute scalar_execute_i (
		.clock(clock),
		.reset(reset),
		.en(en),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_dst(dec_dst),
		.dec_src1_data(dec_src1_data),
		.dec_src2_data(dec_src2_data),
		.dec_imm(dec_imm),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halted(halted),
		.wr_valid(wr_valid),
		.wr_dst(wr_dst),
		.wr_data(wr_data),
		.lane_we(lane_we),
		.lane_data(lane_data)
	);

	scalar_result scalar_result_i (
		.clock(clock),
		.reset(reset),
		.en(en),
		.start(start),
		.halted(halted),
		.rf_ra1(rf_ra1),
		.rf_ra2(rf_ra2),
		.rf_rd1(rf_rd1),
		.rf_rd2(rf_rd2),
		.wr_valid(wr_valid),
		.wr_dst(wr_dst),
		.wr_data(wr_data),
		.lane_we(lane_we),
		.lane_data(lane_data),
		.scalar_valid(scalar_valid),
		.scalar_data(scalar_data),
		.status(status),
		.lane_en(lane_en),
		.term(term)
	);

endmodule

// ==== verif/scalar_unit_tb.sv ====
module scalar_unit_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import scalar_pkg::*;

	localparam int num_rows = 5;
	localparam int prog_words = 16;
	// Each row stores a whole memory image so the store address wraps back to 0
	localparam int store_words = 64;
	localparam int cycle_limit = num_rows * (store_words + 16) * 4 + 100;

	logic clock;
	logic reset;
	logic en;
	logic start;
	logic req_st;
	instr_t instr;
	logic ack_st;
	logic scalar_valid;
	data_t scalar_data;
	status_t status;
	lane_t lane_en;
	logic term;

	// Test table
	instr_t table_prog [num_rows][prog_words];
	logic [prog_words-1:0] table_rand [num_rows];
	logic table_gaps [num_rows];
	lane_t table_lane [num_rows];
	status_t table_status [num_rows];

	instr_t run_prog [prog_words];
	logic [31:0] lfsr;
	data_t model_regs [16];
	lane_t model_lane;
	status_t model_status;
	data_t exp_q [$];
	data_t got_q [$];
	data_t prev_got [$];
	int cycle_count;
	int error_count;
	int check_count;
	int ack_count;
	logic req_prev;

	scalar_unit scalar_unit_i (
		.clock(clock),
		.reset(reset),
		.en(en),
		.start(start),
		.req_st(req_st),
		.instr(instr),
		.ack_st(ack_st),
		.scalar_valid(scalar_valid),
		.scalar_data(scalar_data),
		.status(status),
		.lane_en(lane_en),
		.term(term)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////
	// Stimulus helpers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[14:0], lfsr[0]};
		end
	endtask

	function automatic instr_t encode(input op_t op, input logic [3:0] dst,
			input logic [3:0] src1, input logic [3:0] src2, input logic [15:0] imm);
		return {op, dst, src1, src2, imm};
	endfunction

	// Unused words halt, with the address in the immediate
	function automatic instr_t pad_word(input int addr);
		return encode(op_halt, 4'd0, 4'd0, 4'd0, 16'(addr));
	endfunction

	task automatic compare_data(input string name, input data_t got, input data_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_lane(input string name, input lane_t got, input lane_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_status(input string name, input status_t got, input status_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic load_table();
		for (int r = 0; r < num_rows; r++) begin
			for (int a = 0; a < prog_words; a++) begin
				table_prog[r][a] = pad_word(a);
			end
			table_rand[r] = '0;
			table_gaps[r] = 1'b0;
		end
		// Row 0 dependent ALU chain
		table_prog[0][0] = encode(op_ldi, 4'd1, 4'd0, 4'd0, 16'h0000);
		table_prog[0][1] = encode(op_ldi, 4'd2, 4'd0, 4'd0, 16'h0000);
		table_prog[0][2] = encode(op_add, 4'd3, 4'd1, 4'd2, 16'h0000);
		table_prog[0][3] = encode(op_sub, 4'd4, 4'd3, 4'd1, 16'h0000);
		table_prog[0][4] = encode(op_xor, 4'd5, 4'd4, 4'd3, 16'h0000);
		table_prog[0][5] = encode(op_and, 4'd6, 4'd5, 4'd4, 16'h0000);
		table_prog[0][6] = encode(op_or, 4'd7, 4'd6, 4'd5, 16'h0000);
		table_prog[0][7] = encode(op_ldi, 4'd8, 4'd0, 4'd0, 16'h0003);
		table_prog[0][8] = encode(op_shl, 4'd9, 4'd7, 4'd8, 16'h0000);
		table_prog[0][9] = encode(op_ldi, 4'd10, 4'd0, 4'd0, 16'h00a5);
		table_prog[0][10] = encode(op_lane, 4'd0, 4'd10, 4'd0, 16'h0000);
		table_prog[0][11] = encode(op_ldi, 4'd11, 4'd0, 4'd0, 16'h8000);
		table_prog[0][12] = encode(op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
		table_rand[0] = 16'h0003;
		table_lane[0] = 8'ha5;
		table_status[0] = '{zero: 1'b0, negative: 1'b1};
		// Row 2 jumps and branches, taken and not taken
		table_prog[2][0] = encode(op_ldi, 4'd1, 4'd0, 4'd0, 16'h0000);
		table_prog[2][1] = encode(op_ldi, 4'd2, 4'd0, 4'd0, 16'h0000);
		table_prog[2][2] = encode(op_bz, 4'd0, 4'd1, 4'd0, 16'd5);
		table_prog[2][3] = encode(op_ldi, 4'd3, 4'd0, 4'd0, 16'h1111);
		table_prog[2][4] = encode(op_ldi, 4'd4, 4'd0, 4'd0, 16'h2222);
		table_prog[2][5] = encode(op_bz, 4'd0, 4'd2, 4'd0, 16'd8);
		table_prog[2][6] = encode(op_add, 4'd5, 4'd2, 4'd2, 16'h0000);
		table_prog[2][7] = encode(op_jmp, 4'd0, 4'd0, 4'd0, 16'd10);
		table_prog[2][8] = encode(op_ldi, 4'd6, 4'd0, 4'd0, 16'h3333);
		table_prog[2][9] = encode(op_ldi, 4'd7, 4'd0, 4'd0, 16'h4444);
		table_prog[2][10] = encode(op_ldi, 4'd9, 4'd0, 4'd0, 16'h003c);
		table_prog[2][11] = encode(op_lane, 4'd0, 4'd9, 4'd0, 16'h0000);
		table_prog[2][12] = encode(op_sub, 4'd10, 4'd9, 4'd9, 16'h0000);
		table_prog[2][13] = encode(op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
		table_prog[2][14] = encode(op_ldi, 4'd11, 4'd0, 4'd0, 16'h5555);
		table_prog[2][15] = encode(op_ldi, 4'd12, 4'd0, 4'd0, 16'h6666);
		table_rand[2] = 16'h0002;
		table_lane[2] = 8'h3c;
		table_status[2] = '{zero: 1'b1, negative: 1'b0};
		// Row 4 countdown loop with a backward jump
		table_prog[4][0] = encode(op_ldi, 4'd1, 4'd0, 4'd0, 16'h0003);
		table_prog[4][1] = encode(op_ldi, 4'd2, 4'd0, 4'd0, 16'h0001);
		table_prog[4][2] = encode(op_ldi, 4'd3, 4'd0, 4'd0, 16'h0000);
		table_prog[4][3] = encode(op_sub, 4'd1, 4'd1, 4'd2, 16'h0000);
		table_prog[4][4] = encode(op_add, 4'd3, 4'd3, 4'd1, 16'h0000);
		table_prog[4][5] = encode(op_bz, 4'd0, 4'd1, 4'd0, 16'd7);
		table_prog[4][6] = encode(op_jmp, 4'd0, 4'd0, 4'd0, 16'd3);
		table_prog[4][7] = encode(op_ldi, 4'd4, 4'd0, 4'd0, 16'hff81);
		table_prog[4][8] = encode(op_lane, 4'd0, 4'd4, 4'd0, 16'h0000);
		table_prog[4][9] = encode(op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
		table_rand[4] = 16'h0004;
		table_lane[4] = 8'h81;
		table_status[4] = '{zero: 1'b0, negative: 1'b1};
		// Rows 1 and 3 rerun the row before with en gaps
		table_gaps[1] = 1'b1;
		table_lane[1] = table_lane[0];
		table_status[1] = table_status[0];
		table_gaps[3] = 1'b1;
		table_lane[3] = table_lane[2];
		table_status[3] = table_status[2];
	endtask

	// Gap rows keep the program of the row before, random immediates included
	task automatic prepare_program(input int row);
		logic [15:0] bits;
		if (!table_gaps[row]) begin
			for (int a = 0; a < prog_words; a++) begin
				run_prog[a] = table_prog[row][a];
				if (table_rand[row][a]) begin
					take_bits(16, bits);
					run_prog[a][15:0] = bits;
				end
			end
		end
	endtask

	////////////////////
	// Reference model

	task automatic run_model();
		pc_t pc;
		instr_t w;
		op_t op;
		data_t a;
		data_t b;
		data_t res;
		logic [3:0] dst;
		logic writes;
		logic done;
		int steps;
		pc = '0;
		done = 1'b0;
		steps = 0;
		exp_q.delete();
		while (!done && steps < 256) begin
			w = (pc < prog_words) ? run_prog[pc[3:0]] : pad_word(int'(pc));
			op = op_t'(w[31:28]);
			dst = w[27:24];
			a = model_regs[w[23:20]];
			b = model_regs[w[19:16]];
			res = '0;
			writes = op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_ldi};
			pc = pc + 6'd1;
			steps++;
			case (op)
				op_add: res = a + b;
				op_sub: res = a - b;
				op_and: res = a & b;
				op_or: res = a | b;
				op_xor: res = a ^ b;
				op_shl: res = a << b[4:0];
				op_ldi: res = {{16{w[15]}}, w[15:0]};
				op_jmp: pc = w[5:0];
				op_bz: begin
					if (a == '0) begin
						pc = w[5:0];
					end
				end
				op_lane: model_lane = a[7:0];
				op_halt: done = 1'b1;
				default: res = '0;
			endcase
			// r0 stays zero and never reaches the output
			if (writes && dst != 4'd0) begin
				model_regs[dst] = res;
				exp_q.push_back(res);
				model_status.zero = (res == '0);
				model_status.negative = res[31];
			end
		end
		if (!done) begin
			error_count++;
			$display("Reference model ran 256 steps without reaching a halt");
		end
	endtask

	////////////////////
	// Driving and checking

	task automatic store_image();
		int acks_before;
		acks_before = ack_count;
		for (int a = 0; a < store_words; a++) begin
			req_st = 1'b1;
			instr = (a < prog_words) ? run_prog[a] : pad_word(a);
			@(posedge clock);
			#1;
		end
		req_st = 1'b0;
		instr = '0;
		repeat (2) @(posedge clock);
		#1;
		check_count++;
		if (ack_count - acks_before != store_words) begin
			error_count++;
			$display("Store gave %0d acks for %0d words", ack_count - acks_before, store_words);
		end
	endtask

	task automatic run_program(input logic gaps);
		logic [15:0] bits;
		start = 1'b1;
		en = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		while (!term) begin
			if (gaps) begin
				take_bits(2, bits);
				// Roughly one cycle in four stalled
				en = |bits[1:0];
			end
			@(posedge clock);
			#1;
		end
		en = 1'b1;
		// A few more cycles so that a late result or lane change would show
		repeat (4) @(posedge clock);
		#1;
	endtask

	task automatic check_row(input int row);
		int n;
		if (got_q.size() != exp_q.size()) begin
			error_count++;
			$display("Row %0d gave %0d results where %0d were expected",
				row, got_q.size(), exp_q.size());
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			compare_data("scalar_data", got_q[i], exp_q[i]);
		end
		if (table_gaps[row]) begin
			if (got_q.size() != prev_got.size()) begin
				error_count++;
				$display("Row %0d with en gaps gave %0d results, without gaps %0d",
					row, got_q.size(), prev_got.size());
			end
			for (int i = 0; i < n && i < prev_got.size(); i++) begin
				compare_data("scalar_data", got_q[i], prev_got[i]);
			end
		end
		compare_bit("term", term, 1'b1);
		compare_lane("lane_en", lane_en, model_lane);
		compare_lane("lane_en", lane_en, table_lane[row]);
		compare_status("status", status, model_status);
		compare_status("status", status, table_status[row]);
	endtask

	// Outputs sampled mid-cycle, clear of the edge and of input changes
	always @(negedge clock) begin
		if (!reset) begin
			compare_bit("ack_st", ack_st, req_prev);
			if (ack_st) begin
				ack_count++;
			end
			if (scalar_valid) begin
				if (term) begin
					error_count++;
					$display("scalar_valid was high while term was set");
				end
				got_q.push_back(scalar_data);
			end
		end
		req_prev = req_st;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycle_limit);
		$display("test failed");
		$finish;
	end

	initial begin
		int row_errors;
		reset = 1'b1;
		en = 1'b0;
		start = 1'b0;
		req_st = 1'b0;
		instr = '0;
		lfsr = 32'hb8bf2a74;
		error_count = 0;
		check_count = 0;
		ack_count = 0;
		req_prev = 1'b0;
		for (int r = 0; r < 16; r++) begin
			model_regs[r] = '0;
		end
		model_lane = '0;
		model_status = '0;
		load_table();
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		en = 1'b1;
		for (int row = 0; row < num_rows; row++) begin
			row_errors = error_count;
			prepare_program(row);
			run_model();
			store_image();
			got_q.delete();
			run_program(table_gaps[row]);
			check_row(row);
			$display("Row %0d: %0d results, %0d errors", row, got_q.size(),
				error_count - row_errors);
			prev_got = got_q;
		end
		$display("Rows: %0d, checks: %0d, errors: %0d", num_rows, check_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/scalar_pkg.sv
verilog/instr_mem.sv
verilog/scalar_decode.sv
verilog/scalar_execute.sv
verilog/scalar_result.sv
verilog/scalar_unit.sv
verif/scalar_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the scalar unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module scalar_unit_tb -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vscalar_unit_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1
